// ==== verilog/tl_sim_pkg.sv ====
// ==================================================
// TL-UL simulation memory package.
// Bus structs, opcodes and the window constants
// shared by the SRAM tap and its error sink.
// ==================================================

package tl_sim_pkg;

  // Bus widths.
  localparam int AddrW = 32;
  localparam int DataW = 32;
  localparam int SrcW  = 4;
  localparam int MaskW = DataW / 8;

  // Local RAM window.
  // It spans SimSramBase up to SimSramBase + 4 * SimSramDepth - 1.
  localparam logic [AddrW-1:0] SimSramBase  = 32'h1000_0000;
  localparam int               SimSramDepth = 16;
  localparam int               SimSramAw    = $clog2(SimSramDepth);

  // Request opcodes.
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // Response opcodes.
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // Host to device. The A channel plus the D channel ready.
  typedef struct packed {
    logic             a_valid;
    tl_a_op_e         a_opcode;
    logic [AddrW-1:0] a_address;
    logic [MaskW-1:0] a_mask;
    logic [DataW-1:0] a_data;
    logic [SrcW-1:0]  a_source;
    logic             d_ready;
  } tl_h2d_t;

  // Device to host. The D channel plus the A channel ready.
  typedef struct packed {
    logic             d_valid;
    tl_d_op_e         d_opcode;
    logic [DataW-1:0] d_data;
    logic [SrcW-1:0]  d_source;
    logic             d_error;
    logic             a_ready;
  } tl_d2h_t;

endpackage

// ==== verilog/sim_ram_1p.sv ====
// ==================================================
// Single-port simulation RAM.
// Byte-masked writes, read data one cycle later.
// ==================================================

`timescale 1ns/1ps

module sim_ram_1p (
  input  logic                             clk_i,
  input  logic                             req_i,
  input  logic                             we_i,
  input  logic [tl_sim_pkg::SimSramAw-1:0] addr_i,
  input  logic [tl_sim_pkg::DataW-1:0]     wdata_i,
  input  logic [tl_sim_pkg::MaskW-1:0]     wmask_i,
  output logic [tl_sim_pkg::DataW-1:0]     rdata_o
);

  logic [tl_sim_pkg::DataW-1:0] mem [tl_sim_pkg::SimSramDepth];

  // Writes touch only the enabled bytes.
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < tl_sim_pkg::MaskW; b++) begin
        if (wmask_i[b]) begin
          mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Read port. The word is held until the next read.
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

// ==== verilog/tl_sram_adapter.sv ====
// ==================================================
// TL-UL to SRAM adapter.
// Drives the RAM on request accept and returns
// responses in order from a two-entry queue.
// ==================================================

`timescale 1ns/1ps

module tl_sram_adapter (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // Bus side.
  input  tl_sim_pkg::tl_h2d_t              tl_i,
  output tl_sim_pkg::tl_d2h_t              tl_o,

  // RAM side.
  output logic                             ram_req_o,
  output logic                             ram_we_o,
  output logic [tl_sim_pkg::SimSramAw-1:0] ram_addr_o,
  output logic [tl_sim_pkg::DataW-1:0]     ram_wdata_o,
  output logic [tl_sim_pkg::MaskW-1:0]     ram_wmask_o,
  input  logic [tl_sim_pkg::DataW-1:0]     ram_rdata_i
);

  // One queued response.
  typedef struct packed {
    tl_sim_pkg::tl_d_op_e           op;
    logic [tl_sim_pkg::SrcW-1:0]    source;
    logic [tl_sim_pkg::DataW-1:0]   data;
  } rsp_entry_t;

  rsp_entry_t rsp_q [2];

  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] cnt_q;
  logic       fill_pend_q;
  logic       fill_idx_q;

  logic a_ready;
  logic a_fire;
  logic d_valid;
  logic d_fire;
  logic is_read;

  assign a_ready = (cnt_q < 2'd2);
  assign a_fire  = tl_i.a_valid & a_ready;
  assign d_valid = (cnt_q != 2'd0);
  assign d_fire  = d_valid & tl_i.d_ready;
  assign is_read = (tl_i.a_opcode == tl_sim_pkg::Get);

  // RAM access happens in the accept cycle.
  assign ram_req_o   = a_fire;
  assign ram_we_o    = ~is_read;
  assign ram_addr_o  = tl_i.a_address[tl_sim_pkg::SimSramAw+1:2];
  assign ram_wdata_o = tl_i.a_data;
  assign ram_wmask_o = (tl_i.a_opcode == tl_sim_pkg::PutFullData) ? '1 : tl_i.a_mask;

  // Queue pointers, occupancy and the pending read fill.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q    <= 1'b0;
      rd_ptr_q    <= 1'b0;
      cnt_q       <= 2'd0;
      fill_pend_q <= 1'b0;
      fill_idx_q  <= 1'b0;
    end else begin
      if (a_fire) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (d_fire) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({a_fire, d_fire})
        2'b10:   cnt_q <= cnt_q + 2'd1;
        2'b01:   cnt_q <= cnt_q - 2'd1;
        default: cnt_q <= cnt_q;
      endcase
      fill_pend_q <= a_fire & is_read;
      if (a_fire) begin
        fill_idx_q <= wr_ptr_q;
      end
    end
  end

  // Entry payload. Read data lands one cycle after the access.
  always_ff @(posedge clk_i) begin
    if (a_fire) begin
      rsp_q[wr_ptr_q].op     <= is_read ? tl_sim_pkg::AccessAckData : tl_sim_pkg::AccessAck;
      rsp_q[wr_ptr_q].source <= tl_i.a_source;
      rsp_q[wr_ptr_q].data   <= '0;
    end
    if (fill_pend_q) begin
      rsp_q[fill_idx_q].data <= ram_rdata_i;
    end
  end

  // Head of queue. Bypass the RAM output while its fill is still pending.
  always_comb begin
    tl_o          = '0;
    tl_o.d_valid  = d_valid;
    tl_o.d_opcode = rsp_q[rd_ptr_q].op;
    tl_o.d_source = rsp_q[rd_ptr_q].source;
    tl_o.d_data   = rsp_q[rd_ptr_q].data;
    if (fill_pend_q && (fill_idx_q == rd_ptr_q)) begin
      tl_o.d_data = ram_rdata_i;
    end
    tl_o.d_error  = 1'b0;
    tl_o.a_ready  = a_ready;
  end

endmodule

// ==== verilog/tl_err_sink.sv ====
// ==================================================
// TL-UL error sink.
// Stands for unmapped space and answers every
// request with an error, one at a time.
// ==================================================

`timescale 1ns/1ps

module tl_err_sink (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tl_sim_pkg::tl_h2d_t tl_i,
  output tl_sim_pkg::tl_d2h_t tl_o
);

  logic                        pend_q;
  tl_sim_pkg::tl_d_op_e        op_q;
  logic [tl_sim_pkg::SrcW-1:0] src_q;

  logic a_fire;
  logic d_fire;

  // Only one response may be pending.
  assign a_fire = tl_i.a_valid & ~pend_q;
  assign d_fire = pend_q & tl_i.d_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= 1'b0;
    end else if (a_fire) begin
      pend_q <= 1'b1;
    end else if (d_fire) begin
      pend_q <= 1'b0;
    end
  end

  // Response payload, captured on accept.
  always_ff @(posedge clk_i) begin
    if (a_fire) begin
      op_q  <= (tl_i.a_opcode == tl_sim_pkg::Get) ? tl_sim_pkg::AccessAckData
                                                 : tl_sim_pkg::AccessAck;
      src_q <= tl_i.a_source;
    end
  end

  always_comb begin
    tl_o          = '0;
    tl_o.d_valid  = pend_q;
    tl_o.d_opcode = op_q;
    tl_o.d_data   = '0;
    tl_o.d_source = src_q;
    tl_o.d_error  = 1'b1;
    tl_o.a_ready  = ~pend_q;
  end

endmodule

// ==== verilog/sim_sram.sv ====
// ==================================================
// Simulation SRAM tap on a TL-UL link.
// In-window requests go to a local RAM, all others
// pass to the outbound port, responses in order.
// ==================================================

`timescale 1ns/1ps

module sim_sram (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Inbound link from the host.
  input  tl_sim_pkg::tl_h2d_t tl_in_i,
  output tl_sim_pkg::tl_d2h_t tl_in_o,

  // Outbound link for everything outside the window.
  output tl_sim_pkg::tl_h2d_t tl_out_o,
  input  tl_sim_pkg::tl_d2h_t tl_out_i
);

  tl_sim_pkg::tl_h2d_t tl_sram_h2d;
  tl_sim_pkg::tl_d2h_t tl_sram_d2h;

  logic                             ram_req;
  logic                             ram_we;
  logic [tl_sim_pkg::SimSramAw-1:0] ram_addr;
  logic [tl_sim_pkg::DataW-1:0]     ram_wdata;
  logic [tl_sim_pkg::MaskW-1:0]     ram_wmask;
  logic [tl_sim_pkg::DataW-1:0]     ram_rdata;

  logic       in_win;
  logic       hold;
  logic       a_ready;
  logic       a_fire;
  logic       d_fire;
  logic [1:0] out_cnt_q;
  logic       tgt_sram_q;

  // Window decode.
  assign in_win = (tl_in_i.a_address >= tl_sim_pkg::SimSramBase) &&
                  (tl_in_i.a_address < tl_sim_pkg::SimSramBase +
                   tl_sim_pkg::AddrW'(4 * tl_sim_pkg::SimSramDepth));

  // A switch of target waits until the old target has drained.
  assign hold    = (out_cnt_q != 2'd0) && (tgt_sram_q != in_win);
  assign a_ready = ~hold & (in_win ? tl_sram_d2h.a_ready : tl_out_i.a_ready);
  assign a_fire  = tl_in_i.a_valid & a_ready;
  assign d_fire  = tl_in_o.d_valid & tl_in_i.d_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_cnt_q  <= 2'd0;
      tgt_sram_q <= 1'b0;
    end else begin
      case ({a_fire, d_fire})
        2'b10:   out_cnt_q <= out_cnt_q + 2'd1;
        2'b01:   out_cnt_q <= out_cnt_q - 2'd1;
        default: out_cnt_q <= out_cnt_q;
      endcase
      if (a_fire) begin
        tgt_sram_q <= in_win;
      end
    end
  end

  // Request steering. Payload is shared, valid goes to one side.
  always_comb begin
    tl_sram_h2d         = tl_in_i;
    tl_sram_h2d.a_valid = tl_in_i.a_valid & in_win & ~hold;
    tl_sram_h2d.d_ready = tl_in_i.d_ready & tgt_sram_q;
    tl_out_o            = tl_in_i;
    tl_out_o.a_valid    = tl_in_i.a_valid & ~in_win & ~hold;
    tl_out_o.d_ready    = tl_in_i.d_ready & ~tgt_sram_q;
  end

  // D channel from whichever target is outstanding.
  always_comb begin
    tl_in_o         = tgt_sram_q ? tl_sram_d2h : tl_out_i;
    tl_in_o.a_ready = a_ready;
  end

  tl_sram_adapter u_adapter (
    .clk_i,
    .rst_ni,
    .tl_i        (tl_sram_h2d),
    .tl_o        (tl_sram_d2h),
    .ram_req_o   (ram_req),
    .ram_we_o    (ram_we),
    .ram_addr_o  (ram_addr),
    .ram_wdata_o (ram_wdata),
    .ram_wmask_o (ram_wmask),
    .ram_rdata_i (ram_rdata)
  );

  sim_ram_1p u_ram (
    .clk_i,
    .req_i   (ram_req),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .wmask_i (ram_wmask),
    .rdata_o (ram_rdata)
  );

endmodule

// ==== verilog/sim_sram_top.sv ====
// ==================================================
// Simulation SRAM top level.
// The outbound port ends in an error sink, so any
// access outside the window is answered with error.
// ==================================================

`timescale 1ns/1ps

module sim_sram_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tl_sim_pkg::tl_h2d_t tl_i,
  output tl_sim_pkg::tl_d2h_t tl_o
);

  // Link between the tap and the sink.
  tl_sim_pkg::tl_h2d_t tl_err_h2d;
  tl_sim_pkg::tl_d2h_t tl_err_d2h;

  sim_sram u_sim_sram (
    .clk_i,
    .rst_ni,
    .tl_in_i  (tl_i),
    .tl_in_o  (tl_o),
    .tl_out_o (tl_err_h2d),
    .tl_out_i (tl_err_d2h)
  );

  // Unmapped space.
  tl_err_sink u_err_sink (
    .clk_i,
    .rst_ni,
    .tl_i (tl_err_h2d),
    .tl_o (tl_err_d2h)
  );

endmodule

// ==== verif/tb_clk_gen.sv ====
// ==================================================
// Testbench clock source.
// Free-running clock with a 20 ns period.
// ==================================================

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o
);

  // Half period of 10 ns.
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

endmodule

// ==== verif/sim_sram_chk.sv ====
// ==================================================
// TL-UL protocol checks for the SRAM tap.
// Bound into sim_sram, watches the host D channel.
// ==================================================

`timescale 1ns/1ps

module sim_sram_chk (
  input logic                clk_i,
  input logic                rst_ni,
  input tl_sim_pkg::tl_h2d_t host_req_i,
  input tl_sim_pkg::tl_d2h_t host_rsp_i,
  input logic                sram_d_valid_i,
  input logic                out_d_valid_i
);

  logic [39:0] d_payload;

  assign d_payload = {host_rsp_i.d_opcode, host_rsp_i.d_data,
                      host_rsp_i.d_source, host_rsp_i.d_error};

  // A response waits, unchanged, until the host takes it.
  d_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_rsp_i.d_valid && !host_req_i.d_ready |=> host_rsp_i.d_valid && $stable(d_payload))
    else $error("d_valid dropped or its payload changed before d_ready");

  d_reset_a: assert property (@(posedge clk_i) $rose(rst_ni) |-> !host_rsp_i.d_valid)
    else $error("d_valid high in the first cycle after reset");

  // Only one target may hold responses at a time.
  d_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(sram_d_valid_i && out_d_valid_i))
    else $error("SRAM side and outbound side both offer a response");

endmodule

bind sim_sram sim_sram_chk u_chk (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .host_req_i     (tl_in_i),
  .host_rsp_i     (tl_in_o),
  .sram_d_valid_i (tl_sram_d2h.d_valid),
  .out_d_valid_i  (tl_out_i.d_valid)
);

// ==== verif/sim_sram_tb.sv ====
// ==================================================
// Testbench for the simulation SRAM top level.
// Directed tests against a word-array model of the
// window, with error responses outside of it.
// ==================================================

`timescale 1ns/1ps

module sim_sram_tb;

  logic                clk;
  logic                rst_ni;
  tl_sim_pkg::tl_h2d_t tl_i;
  tl_sim_pkg::tl_d2h_t tl_o;

  logic [31:0] model [tl_sim_pkg::SimSramDepth];
  int          seed;
  int          err_cnt;
  int          chk_cnt;
  int          test_cnt;
  int          wait_max = 50;

  // Fields of the last response taken by get_rsp.
  tl_sim_pkg::tl_d_op_e rsp_op;
  logic [31:0]          rsp_data;
  logic [3:0]           rsp_src;
  logic                 rsp_err;

  tb_clk_gen u_clk (
    .clk_o (clk)
  );

  sim_sram_top uut (
    .clk_i  (clk),
    .rst_ni (rst_ni),
    .tl_i   (tl_i),
    .tl_o   (tl_o)
  );

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic in_window(input logic [31:0] addr);
    return (addr >= tl_sim_pkg::SimSramBase) &&
           (addr < tl_sim_pkg::SimSramBase + 32'(4 * tl_sim_pkg::SimSramDepth));
  endfunction

  function automatic logic [3:0] word_index(input logic [31:0] addr);
    return 4'((addr - tl_sim_pkg::SimSramBase) >> 2);
  endfunction

  // Model write. A full put writes every byte.
  task automatic apply_write(input logic [31:0] addr, input tl_sim_pkg::tl_a_op_e op,
                             input logic [3:0] mask, input logic [31:0] data);
    logic [3:0] en;
    en = (op == tl_sim_pkg::PutFullData) ? 4'hf : mask;
    for (int b = 0; b < 4; b++) begin
      if (en[b]) begin
        model[word_index(addr)][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  // Starts and ends just after a rising edge.
  task automatic send_req(input tl_sim_pkg::tl_a_op_e op, input logic [31:0] addr,
                          input logic [3:0] mask, input logic [31:0] data,
                          input logic [3:0] src);
    int n;
    tl_i.a_valid   = 1'b1;
    tl_i.a_opcode  = op;
    tl_i.a_address = addr;
    tl_i.a_mask    = mask;
    tl_i.a_data    = data;
    tl_i.a_source  = src;
    n = 0;
    @(negedge clk);
    while (!tl_o.a_ready && n < wait_max) begin
      @(negedge clk);
      n++;
    end
    if (!tl_o.a_ready) begin
      err_cnt++;
      $display("timeout at %0t: request to %h was never accepted", $time, addr);
    end
    @(posedge clk);
    #1;
    tl_i.a_valid = 1'b0;
  endtask

  task automatic get_rsp();
    int n;
    tl_i.d_ready = 1'b1;
    n = 0;
    @(negedge clk);
    while (!tl_o.d_valid && n < wait_max) begin
      @(negedge clk);
      n++;
    end
    if (!tl_o.d_valid) begin
      err_cnt++;
      $display("timeout at %0t: no response arrived", $time);
    end
    rsp_op   = tl_o.d_opcode;
    rsp_data = tl_o.d_data;
    rsp_src  = tl_o.d_source;
    rsp_err  = tl_o.d_error;
    @(posedge clk);
    #1;
    tl_i.d_ready = 1'b0;
  endtask

  // One request and its response, checked against the window rule and model.
  task automatic transact(input tl_sim_pkg::tl_a_op_e op, input logic [31:0] addr,
                          input logic [3:0] mask, input logic [31:0] data,
                          input logic [3:0] src);
    logic        hit;
    logic        rd;
    logic [31:0] exp_data;
    hit = in_window(addr);
    rd  = (op == tl_sim_pkg::Get);
    exp_data = 32'h0;
    if (hit && rd) begin
      exp_data = model[word_index(addr)];
    end
    send_req(op, addr, mask, data, src);
    get_rsp();
    if (hit && !rd) begin
      apply_write(addr, op, mask, data);
    end
    check("d_opcode", 32'(rsp_op),
          rd ? 32'(tl_sim_pkg::AccessAckData) : 32'(tl_sim_pkg::AccessAck));
    check("d_source", 32'(rsp_src), 32'(src));
    check("d_error", 32'(rsp_err), 32'(!hit));
    if (rd) begin
      check("d_data", rsp_data, exp_data);
    end
  endtask

  task automatic report_test(input string name, input int e0);
    test_cnt++;
    if (err_cnt == e0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, err_cnt - e0);
    end
  endtask

  task automatic reset_state();
    int e0;
    e0 = err_cnt;
    @(negedge clk);
    check("d_valid", 32'(tl_o.d_valid), 32'd0);
    check("a_ready", 32'(tl_o.a_ready), 32'd1);
    @(posedge clk);
    #1;
    report_test("reset state", e0);
  endtask

  task automatic fill_and_readback();
    int          e0;
    logic [31:0] d;
    e0 = err_cnt;
    // Mask zero, a full put must ignore it.
    for (int i = 0; i < tl_sim_pkg::SimSramDepth; i++) begin
      d = $random(seed);
      transact(tl_sim_pkg::PutFullData, tl_sim_pkg::SimSramBase + 32'(4 * i), 4'h0, d, 4'(i));
    end
    for (int i = 0; i < tl_sim_pkg::SimSramDepth; i++) begin
      transact(tl_sim_pkg::Get, tl_sim_pkg::SimSramBase + 32'(4 * i), 4'hf, 32'h0, 4'(i + 1));
    end
    report_test("fill and readback", e0);
  endtask

  task automatic partial_writes();
    int          e0;
    logic [31:0] r;
    logic [31:0] addr;
    e0 = err_cnt;
    for (int k = 1; k < 15; k++) begin
      r = $random(seed);
      addr = tl_sim_pkg::SimSramBase + {26'h0, r[3:0], 2'b00};
      r = $random(seed);
      transact(tl_sim_pkg::PutPartialData, addr, 4'(k), r, 4'(k));
      transact(tl_sim_pkg::Get, addr, 4'hf, 32'h0, 4'(k + 1));
    end
    report_test("partial writes", e0);
  endtask

  task automatic unmapped_access();
    int e0;
    e0 = err_cnt;
    transact(tl_sim_pkg::Get, 32'h0000_1000, 4'hf, 32'h0, 4'h3);
    transact(tl_sim_pkg::PutFullData, 32'h2000_0000, 4'hf, 32'hdead_beef, 4'h9);
    // Just past either end of the window.
    transact(tl_sim_pkg::Get, tl_sim_pkg::SimSramBase + 32'h40, 4'hf, 32'h0, 4'ha);
    transact(tl_sim_pkg::PutPartialData, tl_sim_pkg::SimSramBase - 32'h4, 4'h3,
             32'h1234_5678, 4'hb);
    transact(tl_sim_pkg::Get, tl_sim_pkg::SimSramBase + 32'h8, 4'hf, 32'h0, 4'hc);
    // An in-window read waits while the sink still owes a response.
    send_req(tl_sim_pkg::Get, 32'h0000_2000, 4'hf, 32'h0, 4'hd);
    tl_i.a_valid   = 1'b1;
    tl_i.a_address = tl_sim_pkg::SimSramBase + 32'hc;
    @(negedge clk);
    check("a_ready", 32'(tl_o.a_ready), 32'd0);
    @(posedge clk);
    #1;
    get_rsp();
    check("d_opcode", 32'(rsp_op), 32'(tl_sim_pkg::AccessAckData));
    check("d_source", 32'(rsp_src), 32'hd);
    check("d_error", 32'(rsp_err), 32'd1);
    check("d_data", rsp_data, 32'h0);
    transact(tl_sim_pkg::Get, tl_sim_pkg::SimSramBase + 32'hc, 4'hf, 32'h0, 4'he);
    report_test("unmapped access", e0);
  endtask

  task automatic backpressure();
    int                   e0;
    int                   n;
    int                   got;
    logic                 acc3;
    logic [31:0]          wdata;
    logic [31:0]          exp_d [3];
    logic [3:0]           exp_s [3];
    tl_sim_pkg::tl_d_op_e exp_o [3];
    e0 = err_cnt;
    wdata = $random(seed);
    tl_i.d_ready = 1'b0;
    send_req(tl_sim_pkg::PutFullData, tl_sim_pkg::SimSramBase + 32'h14, 4'h0, wdata, 4'h5);
    send_req(tl_sim_pkg::Get, tl_sim_pkg::SimSramBase + 32'h14, 4'hf, 32'h0, 4'h6);
    apply_write(tl_sim_pkg::SimSramBase + 32'h14, tl_sim_pkg::PutFullData, 4'h0, wdata);
    exp_o[0] = tl_sim_pkg::AccessAck;
    exp_s[0] = 4'h5;
    exp_d[0] = 32'h0;
    exp_o[1] = tl_sim_pkg::AccessAckData;
    exp_s[1] = 4'h6;
    exp_d[1] = model[5];
    exp_o[2] = tl_sim_pkg::AccessAckData;
    exp_s[2] = 4'h7;
    exp_d[2] = model[9];
    // The third request must stay blocked.
    tl_i.a_valid   = 1'b1;
    tl_i.a_opcode  = tl_sim_pkg::Get;
    tl_i.a_address = tl_sim_pkg::SimSramBase + 32'h24;
    tl_i.a_mask    = 4'hf;
    tl_i.a_source  = 4'h7;
    repeat (5) begin
      @(negedge clk);
      check("a_ready", 32'(tl_o.a_ready), 32'd0);
      @(posedge clk);
      #1;
    end
    tl_i.d_ready = 1'b1;
    got  = 0;
    acc3 = 1'b0;
    n    = 0;
    while ((got < 3 || !acc3) && n < wait_max) begin
      @(negedge clk);
      if (tl_o.d_valid && got < 3) begin
        check("d_opcode", 32'(tl_o.d_opcode), 32'(exp_o[got]));
        check("d_source", 32'(tl_o.d_source), 32'(exp_s[got]));
        check("d_error", 32'(tl_o.d_error), 32'd0);
        if (exp_o[got] == tl_sim_pkg::AccessAckData) begin
          check("d_data", tl_o.d_data, exp_d[got]);
        end
        got++;
      end
      if (!acc3 && tl_o.a_ready) begin
        acc3 = 1'b1;
      end
      @(posedge clk);
      #1;
      if (acc3) begin
        tl_i.a_valid = 1'b0;
      end
      n++;
    end
    tl_i.a_valid = 1'b0;
    tl_i.d_ready = 1'b0;
    if (got < 3 || !acc3) begin
      err_cnt++;
      $display("timeout at %0t: %0d of 3 responses seen after d_ready rose", $time, got);
    end
    report_test("backpressure", e0);
  endtask

  task automatic random_mix();
    int                   e0;
    logic [31:0]          r;
    logic [31:0]          addr;
    logic [31:0]          d;
    tl_sim_pkg::tl_a_op_e op;
    e0 = err_cnt;
    for (int k = 0; k < 40; k++) begin
      r = $random(seed);
      case (r[1:0])
        2'd1:    op = tl_sim_pkg::PutFullData;
        2'd2:    op = tl_sim_pkg::PutPartialData;
        default: op = tl_sim_pkg::Get;
      endcase
      if (r[2]) begin
        addr = tl_sim_pkg::SimSramBase + {26'h0, r[7:4], 2'b00};
      end else begin
        addr = $random(seed);
      end
      d = $random(seed);
      transact(op, addr, r[11:8], d, r[15:12]);
    end
    report_test("random mix", e0);
  endtask

  initial begin
    seed     = 32'hf3c52c7e;
    err_cnt  = 0;
    chk_cnt  = 0;
    test_cnt = 0;
    tl_i     = '0;
    rst_ni   = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_ni = 1'b1;
    reset_state();
    fill_and_readback();
    partial_writes();
    unmapped_access();
    backpressure();
    random_mix();
    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== build.f ====
verilog/tl_sim_pkg.sv
verilog/sim_ram_1p.sv
verilog/tl_sram_adapter.sv
verilog/tl_err_sink.sv
verilog/sim_sram.sv
verilog/sim_sram_top.sv
verif/tb_clk_gen.sv
verif/sim_sram_chk.sv
verif/sim_sram_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := sim_sram_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJ_DIR)
